// ==== files.f ====
src/xaui_pkg.sv
src/mgt_pkg.sv
src/xaui_tx_encoder.sv
src/xaui_rx_decoder.sv
src/mgt_reset_ctrl.sv
src/xaui_link_status.sv
src/xaui_phy.sv
dv/tb_clock_gen.sv
dv/xaui_phy_checker.sv
dv/tb_xaui_phy.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_xaui_phy
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_xaui_phy.sv ====
module tb_xaui_phy
  import xaui_pkg::*;
  import mgt_pkg::*;
();

  localparam int clk_period    = 4;
  localparam int reset_cycles  = 16;
  localparam int num_cycles    = 2000;
  localparam int watchdog_time = (reset_cycles + num_cycles + 100) * clk_period;

  logic       mgt_clk;
  logic       mgt_rx_reset_stretch;
  logic       xaui_reset;
  logic [7:0] xaui_status;
  xgmii_col_t xgmii_tx;
  xgmii_col_t xgmii_rx;
  mgt_tx_t    mgt_tx;
  mgt_rx_t    mgt_rx;
  mgt_ctrl_t  mgt_ctrl;

  int seed = 68;
  int pulse_left = 0;
  int errors = 0;
  int cycles_checked = 0;

  // model state, updated on the same edge the DUT samples.
  mgt_tx_t    exp_tx;
  xgmii_col_t exp_rx;
  int         tx_count;
  int         rx_count;
  logic [3:0] exp_align;
  logic       exp_chan_sync;
  logic [7:0] exp_status;
  logic       model_ready = 1'b0;

  tb_clock_gen #(.period(clk_period)) tb_clock_gen_inst (.mgt_clk(mgt_clk));

  xaui_phy xaui_phy_inst (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .xgmii_tx             (xgmii_tx),
    .xgmii_rx             (xgmii_rx),
    .mgt_tx               (mgt_tx),
    .mgt_rx               (mgt_rx),
    .mgt_ctrl             (mgt_ctrl),
    .xaui_reset           (xaui_reset),
    .xaui_status          (xaui_status)
  );

  function automatic int rand_below(int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic mgt_tx_t encode_column(xgmii_col_t col);
    mgt_tx_t    t;
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      b = col.data[8*i +: 8];
      t.txcharisk[i] = col.ctrl[i];
      if (col.ctrl[i] && b == xgmii_idle) begin
        t.txdata[8*i +: 8] = char_k;
      end else begin
        t.txdata[8*i +: 8] = b;
      end
    end
    return t;
  endfunction

  function automatic xgmii_col_t decode_column(mgt_rx_t rx);
    xgmii_col_t c;
    logic [7:0] b;
    logic       is_comma;
    for (int i = 0; i < 8; i++) begin
      b = rx.rxdata[8*i +: 8];
      is_comma = (b == char_k) || (b == char_a) || (b == char_r);
      c.ctrl[i] = 1'b1;
      if (!rx.syncok[i/2]) begin
        c.data[8*i +: 8] = xgmii_idle;
      end else if (!rx.code_valid[i]) begin
        c.data[8*i +: 8] = xgmii_error;
      end else if (rx.rxcharisk[i] && is_comma) begin
        c.data[8*i +: 8] = xgmii_idle;
      end else begin
        c.data[8*i +: 8] = b;
        c.ctrl[i] = rx.rxcharisk[i];
      end
    end
    return c;
  endfunction

  function automatic logic code_fault_seen(mgt_rx_t rx);
    logic fault;
    fault = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (rx.syncok[i/2] && !rx.code_valid[i]) begin
        fault = 1'b1;
      end
    end
    return fault;
  endfunction

  task automatic drive_inputs();
    xgmii_col_t  col;
    mgt_rx_t     rx;
    logic [31:0] r;
    int          k;
    col.data = {$random(seed), $random(seed)};
    r = $random(seed);
    col.ctrl = r[7:0];
    for (int i = 0; i < 8; i++) begin
      if (col.ctrl[i] && rand_below(2) == 0) begin
        col.data[8*i +: 8] = xgmii_idle;  // half of the control bytes are idles.
      end
    end
    rx.rxdata = {$random(seed), $random(seed)};
    r = $random(seed);
    rx.rxcharisk = r[7:0];
    rx.code_comma = r[15:8];
    for (int i = 0; i < 8; i++) begin
      k = rand_below(8);
      if (k == 0) begin
        rx.rxdata[8*i +: 8] = char_k;
      end else if (k == 1) begin
        rx.rxdata[8*i +: 8] = char_a;
      end else if (k == 2) begin
        rx.rxdata[8*i +: 8] = char_r;
      end
      rx.code_valid[i] = (rand_below(16) != 0);
    end
    for (int i = 0; i < 4; i++) begin
      rx.syncok[i]    = (rand_below(8) != 0);
      rx.rxlock[i]    = (rand_below(8) != 0);
      rx.rxbufferr[i] = (rand_below(256) == 0);  // buffer errors are rare.
    end
    xgmii_tx <= col;
    mgt_rx   <= rx;
    if (pulse_left > 0) begin
      xaui_reset <= 1'b1;
      pulse_left--;
    end else if (rand_below(100) == 0) begin
      xaui_reset <= 1'b1;
      pulse_left = rand_below(3);  // pulses last one to three cycles.
    end else begin
      xaui_reset <= 1'b0;
    end
  endtask

  task automatic report_mismatch(string name, logic [71:0] got, logic [71:0] exp);
    errors++;
    $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  always @(posedge mgt_clk) begin
    model_ready <= 1'b1;
    if (mgt_rx_reset_stretch) begin
      exp_tx.txdata    <= {8{char_k}};
      exp_tx.txcharisk <= 8'hFF;
      exp_rx.data      <= {8{xgmii_idle}};
      exp_rx.ctrl      <= 8'hFF;
      tx_count         <= int'(reset_stretch);
      rx_count         <= int'(reset_stretch);
      exp_align        <= 4'hF;
      exp_chan_sync    <= 1'b0;
      exp_status       <= 8'h00;
    end else begin
      exp_tx <= encode_column(xgmii_tx);
      exp_rx <= decode_column(mgt_rx);
      if (xaui_reset) begin
        tx_count <= int'(reset_stretch);
      end else if (tx_count != 0) begin
        tx_count <= tx_count - 1;
      end
      if (xaui_reset || mgt_rx.rxbufferr != 4'h0) begin
        rx_count <= int'(reset_stretch);
      end else if (rx_count != 0) begin
        rx_count <= rx_count - 1;
      end
      exp_align       <= ~mgt_rx.syncok;
      exp_chan_sync   <= (mgt_rx.syncok == 4'hF);
      exp_status[3:0] <= mgt_rx.syncok;
      exp_status[4]   <= (mgt_rx.syncok == 4'hF) && (mgt_rx.code_valid == 8'hFF);
      if (xaui_reset) begin
        exp_status[5] <= 1'b0;
        exp_status[6] <= 1'b0;
      end else begin
        if (code_fault_seen(mgt_rx)) begin
          exp_status[5] <= 1'b1;
        end
        if (mgt_rx.rxbufferr != 4'h0) begin
          exp_status[6] <= 1'b1;
        end
      end
      exp_status[7] <= (mgt_rx.rxlock == 4'hF);
    end
  end

  // outputs are compared half a cycle after the edge, where they are settled.
  always @(negedge mgt_clk) begin
    if (model_ready) begin
      cycles_checked++;
      if (mgt_tx !== exp_tx) begin
        report_mismatch("mgt_tx", mgt_tx, exp_tx);
      end
      if (xgmii_rx !== exp_rx) begin
        report_mismatch("xgmii_rx", xgmii_rx, exp_rx);
      end
      if (mgt_ctrl.tx_reset !== {4{tx_count != 0}}) begin
        report_mismatch("tx_reset", 72'(mgt_ctrl.tx_reset), 72'({4{tx_count != 0}}));
      end
      if (mgt_ctrl.rx_reset !== {4{rx_count != 0}}) begin
        report_mismatch("rx_reset", 72'(mgt_ctrl.rx_reset), 72'({4{rx_count != 0}}));
      end
      if (mgt_ctrl.enable_align !== exp_align) begin
        report_mismatch("enable_align", 72'(mgt_ctrl.enable_align), 72'(exp_align));
      end
      if (mgt_ctrl.en_chan_sync !== exp_chan_sync) begin
        report_mismatch("en_chan_sync", 72'(mgt_ctrl.en_chan_sync), 72'(exp_chan_sync));
      end
      if (xaui_status !== exp_status) begin
        report_mismatch("xaui_status", 72'(xaui_status), 72'(exp_status));
      end
    end
  end

  initial begin
    mgt_rx_reset_stretch <= 1'b1;
    xaui_reset           <= 1'b0;
    xgmii_tx.data        <= {8{xgmii_idle}};
    xgmii_tx.ctrl        <= 8'hFF;
    mgt_rx               <= '0;
    repeat (reset_cycles) @(posedge mgt_clk);
    mgt_rx_reset_stretch <= 1'b0;
    repeat (num_cycles) begin
      @(posedge mgt_clk);
      drive_inputs();
    end
    // the last column is checked on the falling edge before this second rising edge.
    repeat (2) @(posedge mgt_clk);
    $display("cycles checked %0d, errors %0d", cycles_checked, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_time);
    $display("timeout: the run did not reach its end in time");
    $display("Test failed");
    $finish;
  end

endmodule

// ==== dv/xaui_phy_checker.sv ====
module xaui_phy_checker
  import xaui_pkg::*;
  import mgt_pkg::*;
(
  input logic       mgt_clk,
  input logic       mgt_rx_reset_stretch,
  input logic       xaui_reset,
  input xgmii_col_t xgmii_tx,
  input mgt_tx_t    mgt_tx,
  input mgt_rx_t    mgt_rx,
  input mgt_ctrl_t  mgt_ctrl
);

  reset_bits_uniform: assert property (@(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
      mgt_ctrl.tx_reset == {4{mgt_ctrl.tx_reset[0]}} &&
      mgt_ctrl.rx_reset == {4{mgt_ctrl.rx_reset[0]}})
    else $error("transceiver reset bits are not all equal");

  tx_reset_follows_trigger: assert property (@(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
      xaui_reset |=> mgt_ctrl.tx_reset[0])
    else $error("tx_reset did not rise after xaui_reset");

  // the output after the last reset cycle still holds the reset pattern.
  charisk_tracks_ctrl: assert property (@(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
      !$past(mgt_rx_reset_stretch) |-> mgt_tx.txcharisk == $past(xgmii_tx.ctrl))
    else $error("txcharisk does not match the previous ctrl flags");

  chan_sync_needs_all_lanes: assert property (@(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
      mgt_ctrl.en_chan_sync |-> $past(mgt_rx.syncok) == 4'hF)
    else $error("en_chan_sync set without all lanes synced");

endmodule

bind xaui_phy xaui_phy_checker xaui_phy_checker_inst (
  .mgt_clk              (mgt_clk),
  .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
  .xaui_reset           (xaui_reset),
  .xgmii_tx             (xgmii_tx),
  .mgt_tx               (mgt_tx),
  .mgt_rx               (mgt_rx),
  .mgt_ctrl             (mgt_ctrl)
);

// ==== dv/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int period = 4
) (
  output logic mgt_clk
);

  initial begin
    mgt_clk = 1'b0;
  end

  always #(period / 2) mgt_clk = ~mgt_clk;

endmodule

// ==== src/xaui_phy.sv ====
module xaui_phy
  import xaui_pkg::*;
  import mgt_pkg::*;
(
  input  logic       mgt_clk,
  input  logic       mgt_rx_reset_stretch,
  input  xgmii_col_t xgmii_tx,
  output xgmii_col_t xgmii_rx,
  output mgt_tx_t    mgt_tx,
  input  mgt_rx_t    mgt_rx,
  output mgt_ctrl_t  mgt_ctrl,
  input  logic       xaui_reset,
  output logic [7:0] xaui_status
);

  logic [3:0] tx_reset;
  logic [3:0] rx_reset;
  logic [3:0] enable_align;
  logic       en_chan_sync;

  assign mgt_ctrl = '{enable_align: enable_align,
                      en_chan_sync: en_chan_sync,
                      tx_reset:     tx_reset,
                      rx_reset:     rx_reset};

  xaui_tx_encoder xaui_tx_encoder_inst (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .xgmii_tx             (xgmii_tx),
    .mgt_tx               (mgt_tx)
  );

  xaui_rx_decoder xaui_rx_decoder_inst (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .mgt_rx               (mgt_rx),
    .xgmii_rx             (xgmii_rx)
  );

  mgt_reset_ctrl mgt_reset_ctrl_inst (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .xaui_reset           (xaui_reset),
    .rxbufferr            (mgt_rx.rxbufferr),
    .tx_reset             (tx_reset),
    .rx_reset             (rx_reset)
  );

  xaui_link_status xaui_link_status_inst (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .xaui_reset           (xaui_reset),
    .mgt_rx               (mgt_rx),
    .enable_align         (enable_align),
    .en_chan_sync         (en_chan_sync),
    .xaui_status          (xaui_status)
  );

endmodule

// ==== src/xaui_link_status.sv ====
module xaui_link_status
  import mgt_pkg::*;
(
  input  logic       mgt_clk,
  input  logic       mgt_rx_reset_stretch,
  input  logic       xaui_reset,
  input  mgt_rx_t    mgt_rx,
  output logic [3:0] enable_align,
  output logic       en_chan_sync,
  output logic [7:0] xaui_status
);

  logic [7:0] byte_synced;
  logic       code_fault;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      byte_synced[i] = mgt_rx.syncok[i/2];
    end
  end

  // a code error only counts on a lane that has already found its commas.
  assign code_fault = |(~mgt_rx.code_valid & byte_synced);

  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch) begin
      enable_align <= '1;
      en_chan_sync <= 1'b0;
      xaui_status  <= '0;
    end else begin
      enable_align     <= ~mgt_rx.syncok;  // keep hunting for commas on unsynced lanes.
      en_chan_sync     <= &mgt_rx.syncok;
      xaui_status[3:0] <= mgt_rx.syncok;
      xaui_status[4]   <= (&mgt_rx.syncok) & (&mgt_rx.code_valid);
      if (xaui_reset) begin
        xaui_status[5] <= 1'b0;
      end else if (code_fault) begin
        xaui_status[5] <= 1'b1;
      end
      if (xaui_reset) begin
        xaui_status[6] <= 1'b0;
      end else if (|mgt_rx.rxbufferr) begin
        xaui_status[6] <= 1'b1;
      end
      xaui_status[7]   <= &mgt_rx.rxlock;
    end
  end

endmodule

// ==== src/mgt_reset_ctrl.sv ====
module mgt_reset_ctrl
  import mgt_pkg::*;
(
  input  logic       mgt_clk,
  input  logic       mgt_rx_reset_stretch,
  input  logic       xaui_reset,
  input  logic [3:0] rxbufferr,
  output logic [3:0] tx_reset,
  output logic [3:0] rx_reset
);

  logic [1:0] trigger;
  logic [3:0] count [2];

  // index 0 is the transmit side and index 1 the receive side.
  assign trigger[0] = xaui_reset;
  assign trigger[1] = xaui_reset | (|rxbufferr);  // a buffer error restarts the receiver.

  always_ff @(posedge mgt_clk) begin
    for (int i = 0; i < 2; i++) begin
      if (mgt_rx_reset_stretch || trigger[i]) begin
        count[i] <= reset_stretch;
      end else if (count[i] != 4'd0) begin
        count[i] <= count[i] - 4'd1;
      end
    end
  end

  // the output drops once the counter has run out after the last trigger.
  assign tx_reset = {4{count[0] != 4'd0}};
  assign rx_reset = {4{count[1] != 4'd0}};

endmodule

// ==== src/xaui_rx_decoder.sv ====
module xaui_rx_decoder
  import xaui_pkg::*;
  import mgt_pkg::*;
(
  input  logic       mgt_clk,
  input  logic       mgt_rx_reset_stretch,
  input  mgt_rx_t    mgt_rx,
  output xgmii_col_t xgmii_rx
);

  xgmii_col_t rx_next;

  // rules are checked in order, so an unsynced lane hides any code error on it.
  always_comb begin
    rx_next = '0;
    for (int i = 0; i < 2 * lanes; i++) begin
      if (!mgt_rx.syncok[i/2]) begin
        rx_next.data[8*i +: 8] = xgmii_idle;
        rx_next.ctrl[i]        = 1'b1;
      end else if (!mgt_rx.code_valid[i]) begin
        rx_next.data[8*i +: 8] = xgmii_error;
        rx_next.ctrl[i]        = 1'b1;
      end else if (mgt_rx.rxcharisk[i] &&
                   (mgt_rx.rxdata[8*i +: 8] == char_k ||
                    mgt_rx.rxdata[8*i +: 8] == char_a ||
                    mgt_rx.rxdata[8*i +: 8] == char_r)) begin
        rx_next.data[8*i +: 8] = xgmii_idle;  // idle sequence characters collapse to idle.
        rx_next.ctrl[i]        = 1'b1;
      end else if (mgt_rx.rxcharisk[i]) begin
        rx_next.data[8*i +: 8] = mgt_rx.rxdata[8*i +: 8];
        rx_next.ctrl[i]        = 1'b1;
      end else begin
        rx_next.data[8*i +: 8] = mgt_rx.rxdata[8*i +: 8];
        rx_next.ctrl[i]        = 1'b0;
      end
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch) begin
      xgmii_rx.data <= {(2 * lanes){xgmii_idle}};
      xgmii_rx.ctrl <= '1;
    end else begin
      xgmii_rx <= rx_next;
    end
  end

endmodule

// ==== src/xaui_tx_encoder.sv ====
module xaui_tx_encoder
  import xaui_pkg::*;
  import mgt_pkg::*;
(
  input  logic       mgt_clk,
  input  logic       mgt_rx_reset_stretch,
  input  xgmii_col_t xgmii_tx,
  output mgt_tx_t    mgt_tx
);

  mgt_tx_t tx_next;

  always_comb begin
    tx_next = '0;
    for (int i = 0; i < 2 * lanes; i++) begin
      if (!xgmii_tx.ctrl[i]) begin
        tx_next.txdata[8*i +: 8] = xgmii_tx.data[8*i +: 8];
        tx_next.txcharisk[i]     = 1'b0;
      end else if (xgmii_tx.data[8*i +: 8] == xgmii_idle) begin
        tx_next.txdata[8*i +: 8] = char_k;  // every idle goes out as a comma.
        tx_next.txcharisk[i]     = 1'b1;
      end else begin
        tx_next.txdata[8*i +: 8] = xgmii_tx.data[8*i +: 8];
        tx_next.txcharisk[i]     = 1'b1;
      end
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch) begin
      mgt_tx.txdata    <= {(2 * lanes){char_k}};  // keep the far end's comma detect busy.
      mgt_tx.txcharisk <= '1;
    end else begin
      mgt_tx <= tx_next;
    end
  end

endmodule

// ==== src/mgt_pkg.sv ====
package mgt_pkg;

  // transmit data and per-byte k flags toward the four transceivers.
  typedef struct packed {
    logic [63:0] txdata;
    logic [7:0]  txcharisk;
  } mgt_tx_t;

  typedef struct packed {
    logic [63:0] rxdata;
    logic [7:0]  rxcharisk;
    logic [7:0]  code_valid;  // one bit per byte, low on a disparity or code error.
    logic [7:0]  code_comma;
    logic [3:0]  rxbufferr;   // elastic buffer over or underflow, per lane.
    logic [3:0]  rxlock;
    logic [3:0]  syncok;
  } mgt_rx_t;

  typedef struct packed {
    logic [3:0] enable_align;
    logic       en_chan_sync;
    logic [3:0] tx_reset;
    logic [3:0] rx_reset;
  } mgt_ctrl_t;

  localparam logic [3:0] reset_stretch = 4'd8;  // cycles a transceiver reset outlasts its trigger.

endpackage

// ==== src/xaui_pkg.sv ====
package xaui_pkg;

  localparam int lanes = 4;  // each lane carries two bytes of a column.

  // byte i of data belongs to lane i/2, and ctrl bit i flags byte i as a control character.
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  ctrl;
  } xgmii_col_t;

  localparam logic [7:0] xgmii_idle  = 8'h07;
  localparam logic [7:0] xgmii_error = 8'hFE;

  localparam logic [7:0] char_k = 8'hBC;  // K28.5, the comma sent in place of idles.
  localparam logic [7:0] char_a = 8'h7C;  // K28.3, the alignment character.
  localparam logic [7:0] char_r = 8'h1C;  // K28.0, the skip character.

endpackage
